// ==== build.f ====
rtl/eeprom_pkg.sv
rtl/eeprom_req_if.sv
rtl/i2c_step_if.sv
rtl/eeprom_request_stage.sv
rtl/eeprom_sequencer.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_ctrl.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

// ==== Bender.yml ====
package:
  name: eeprom_ctrl

sources:
  - files:
      - rtl/eeprom_pkg.sv
      - rtl/eeprom_req_if.sv
      - rtl/i2c_step_if.sv
      - rtl/eeprom_request_stage.sv
      - rtl/eeprom_sequencer.sv
      - rtl/i2c_bit_engine.sv
      - rtl/eeprom_ctrl.sv
  - target: test
    files:
      - bench/eeprom_model.sv
      - bench/tb_eeprom_ctrl.sv

// ==== bench/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ns
module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int SEED       = 20647;
    localparam int MEM_SIZE   = 2048;
    localparam int CLK_DIV    = 2;
    localparam int NUM_RAND   = 8;
    localparam int TXN_CYCLES = 400;    // above a random read of about 335 cycles
    localparam int NUM_TXN    = 2 * NUM_RAND + 16 + 4 + 3;
    localparam int MAX_CYCLES = NUM_TXN * TXN_CYCLES + 200;
    localparam int FULL_WRITE_CYCLES = CLK_DIV * (4 + 3 * 36 + 4);  // start, three bytes, stop

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              busy;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              nack;
    logic              scl;
    wire               sda;
    logic              ack_disable;
    logic [DATA_W-1:0] shadow [MEM_SIZE];   // expected memory contents
    int                cycle_cnt = 0;

    pullup (sda);

    eeprom_ctrl #(.CLK_DIV(CLK_DIV)) eeprom_ctrl_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model model_i (
        .scl         (scl),
        .sda         (sda),
        .ack_disable (ack_disable)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES)
            fail_run("timeout: the run went past its cycle limit without finishing");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            fail_run($sformatf("mismatch at %0t ns: %s, got %0h, expected %0h",
                               $time, what, actual, expected));
    endtask

    // same fill as the model memory
    function automatic logic [DATA_W-1:0] initial_byte(input int a);
        return DATA_W'((a * 29) ^ (a >> 8));
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic request(input logic is_write, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d);
        wr    = is_write;
        rd    = ~is_write;
        addr  = a;
        wdata = d;
        next_cycle();
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        do
            next_cycle();
        while (ack !== 1'b1);
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        request(1'b1, a, d);
        wait_ack();
        check_equal(nack, 0, $sformatf("nack after write to %0h", a));
        shadow[a] = d;
    endtask

    task automatic read_byte(input logic [ADDR_W-1:0] a);
        request(1'b0, a, '0);
        wait_ack();
        check_equal(nack, 0, $sformatf("nack after read of %0h", a));
        check_equal(rdata, shadow[a], $sformatf("read data at %0h", a));
    endtask

    task automatic reset_values();
        check_equal(ack, 0, "ack after reset");
        check_equal(busy, 0, "busy after reset");
        check_equal(scl, 1, "scl after reset");
        check_equal(sda, 1, "sda after reset");
    endtask

    task automatic write_read_back();
        logic [ADDR_W-1:0] a [NUM_RAND];
        int i;
        for (i = 0; i < NUM_RAND; i++)
        begin
            a[i] = ADDR_W'($urandom_range(MEM_SIZE - 1, 0));
            write_byte(a[i], DATA_W'($urandom));
        end
        for (i = 0; i < NUM_RAND; i++)
            read_byte(a[i]);
    endtask

    // same low byte in all eight blocks
    task automatic block_separation();
        logic [DATA_W-1:0] low;
        logic [DATA_W-1:0] base;
        int b;
        low  = DATA_W'($urandom);
        base = DATA_W'($urandom);
        for (b = 0; b < 8; b++)
            write_byte({3'(b), low}, base + DATA_W'(b * 37));
        for (b = 0; b < 8; b++)
            read_byte({3'(b), low});
    endtask

    task automatic queued_requests();
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        logic [DATA_W-1:0] d1;
        int acks;
        a1 = ADDR_W'($urandom_range(MEM_SIZE - 1, 0));
        a2 = a1 ^ 11'h400;
        d1 = DATA_W'($urandom);
        request(1'b1, a1, d1);
        while (busy === 1'b1)
            next_cycle();
        request(1'b0, a1, '0);              // waits in the slot
        check_equal(busy, 1, "busy with a queued request");
        request(1'b1, a2, ~shadow[a2]);     // dropped while the slot is full
        wait_ack();
        check_equal(nack, 0, "nack on the first queued write");
        shadow[a1] = d1;
        wait_ack();
        check_equal(nack, 0, "nack on the queued read");
        check_equal(rdata, shadow[a1], "queued read data");
        acks = 0;
        repeat (TXN_CYCLES)
        begin
            next_cycle();
            if (ack === 1'b1)
                acks++;
        end
        check_equal(acks, 0, "acks from the dropped request");
        read_byte(a2);
    endtask

    task automatic slave_refusal();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        int waited;
        a = ADDR_W'($urandom_range(MEM_SIZE - 1, 0));
        d = DATA_W'($urandom);
        write_byte(a, d);
        ack_disable = 1'b1;
        request(1'b1, a, ~d);
        waited = 0;
        do
        begin
            next_cycle();
            waited++;
        end
        while (ack !== 1'b1);
        check_equal(nack, 1, "nack with the slave silent");
        check_equal(waited < FULL_WRITE_CYCLES, 1, "ack before a full write could finish");
        ack_disable = 1'b0;
        read_byte(a);       // memory must be unchanged
    endtask

    initial
    begin
        int k;
        int seed_val;
        seed_val    = $urandom(SEED);
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        ack_disable = 1'b0;
        for (k = 0; k < MEM_SIZE; k++)
            shadow[k] = initial_byte(k);
        repeat (3) next_cycle();
        RESET = 1'b0;
        next_cycle();
        reset_values();
        write_read_back();
        block_separation();
        queued_requests();
        slave_refusal();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== bench/eeprom_model.sv ====
`timescale 1ns/1ns
module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic ack_disable
);
    import eeprom_pkg::*;

    localparam int MEM_SIZE = 2048;
    localparam int EV_BYTE  = 0;
    localparam int EV_START = 1;
    localparam int EV_STOP  = 2;

    logic [DATA_W-1:0] mem [MEM_SIZE];
    logic              drive_low;
    logic [ADDR_W-1:0] ptr;
    logic [DATA_W-1:0] ctrl;
    logic [DATA_W-1:0] word;
    int                ev;

    assign sda = drive_low ? 1'b0 : 1'bz;   // open drain

    function automatic logic [DATA_W-1:0] fill_byte(input int a);
        return DATA_W'((a * 29) ^ (a >> 8));
    endfunction

    task automatic wait_start();
        logic seen;
        seen = 1'b0;
        while (!seen)
        begin
            @(negedge sda);
            seen = (scl === 1'b1);
        end
    endtask

    // shift in on rising scl, a start or stop ends the byte early
    task automatic recv_byte(output logic [DATA_W-1:0] val, output int cond);
        logic b;
        int   n;
        val  = '0;
        cond = EV_BYTE;
        n    = 0;
        while (n < DATA_W && cond == EV_BYTE)
        begin
            @(posedge scl);
            b = sda;
            @(scl or sda);
            if (scl === 1'b1)
                cond = (sda === 1'b0) ? EV_START : EV_STOP;
            else
                val = {val[DATA_W-2:0], b};
            n++;
        end
    endtask

    task automatic give_ack();
        drive_low = 1'b1;
        @(negedge scl);
        drive_low = 1'b0;
    endtask

    task automatic send_byte(input logic [DATA_W-1:0] val);
        int n;
        for (n = DATA_W - 1; n >= 0; n--)
        begin
            drive_low = ~val[n];    // changes only while scl is low
            @(negedge scl);
        end
        drive_low = 1'b0;
        @(negedge scl);             // master ack slot
    endtask

    initial
    begin
        int k;
        for (k = 0; k < MEM_SIZE; k++)
            mem[k] = fill_byte(k);
        drive_low = 1'b0;
        ptr       = '0;
        ev        = EV_STOP;
        forever
        begin
            if (ev != EV_START)
                wait_start();
            recv_byte(ctrl, ev);
            if (ev == EV_BYTE)
            begin
                ev = EV_STOP;
                if (ctrl[7:4] == DEV_CODE && !ack_disable)
                begin
                    give_ack();
                    ptr[ADDR_W-1:DATA_W] = ctrl[3:1];   // block number
                    if (ctrl[0])
                        send_byte(mem[ptr]);
                    else
                    begin
                        recv_byte(word, ev);
                        if (ev == EV_BYTE)
                        begin
                            ptr[DATA_W-1:0] = word;
                            give_ack();
                            recv_byte(word, ev);    // data, or a repeated start
                            if (ev == EV_BYTE)
                            begin
                                mem[ptr] = word;
                                give_ack();
                                ev = EV_STOP;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/eeprom_ctrl.sv ====
`timescale 1ns/1ns
module eeprom_ctrl #(
    parameter int CLK_DIV = 2
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          busy,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          nack,
    output logic                          scl,
    inout  wire                           sda
);

    logic sda_drive_low;

    eeprom_req_if req_if ();
    i2c_step_if   step_if ();

    // open drain, pull-up is external
    assign sda = sda_drive_low ? 1'b0 : 1'bz;

    eeprom_request_stage req_stage_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .req   (req_if.holder)
    );

    eeprom_sequencer seq_i (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req_if.taker),
        .step  (step_if.master),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack)
    );

    i2c_bit_engine #(.CLK_DIV(CLK_DIV)) bit_engine_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .step          (step_if.engine),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

endmodule

// ==== rtl/i2c_bit_engine.sv ====
`timescale 1ns/1ns
module i2c_bit_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    i2c_step_if.engine step,
    output logic       scl,
    output logic       sda_drive_low,
    input  logic       sda_in
);
    import eeprom_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV + 1);

    logic [DIV_W-1:0]  div_cnt;
    logic              tick;
    logic              active;
    logic [1:0]        qtr;       // quarter of the SCL period
    logic [3:0]        bit_cnt;
    logic [3:0]        last_bit;
    logic              ack_bit;
    logic              q0_drive;
    i2c_op_t           op_q;
    logic              nack_q;
    logic [DATA_W-1:0] tx_sr;
    logic [DATA_W-1:0] rx_sr;

    assign tick         = active & (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_bit     = (op_q == OP_SEND || op_q == OP_RECV) ? 4'd8 : 4'd0;
    assign ack_bit      = (bit_cnt == 4'd8);
    assign step.rx_byte = rx_sr;

    // sda level set in the first quarter, scl is low there
    always_comb
    begin
        case (op_q)
            OP_START: q0_drive = 1'b0;
            OP_STOP:  q0_drive = 1'b1;
            OP_SEND:  q0_drive = ack_bit ? 1'b0 : ~tx_sr[DATA_W-1];
            default:  q0_drive = ack_bit ? ~nack_q : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            div_cnt <= '0;
        else if (step.go || tick)
            div_cnt <= '0;
        else if (active)
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active          <= 1'b0;
            step.done       <= 1'b0;
            step.slave_nack <= 1'b0;
            qtr             <= 2'd0;
            bit_cnt         <= 4'd0;
            scl             <= 1'b1;
            sda_drive_low   <= 1'b0;
        end
        else
        begin
            step.done <= tick & (qtr == 2'd3) & (bit_cnt == last_bit);
            if (step.go)
            begin
                active  <= 1'b1;
                qtr     <= 2'd0;
                bit_cnt <= 4'd0;
            end
            else if (tick)
            begin
                qtr <= qtr + 2'd1;
                if (qtr == 2'd3)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == last_bit)
                        active <= 1'b0;
                end
                case (qtr)
                    2'd0: sda_drive_low <= q0_drive;
                    2'd1: scl <= 1'b1;
                    2'd2:
                    begin
                        if (op_q == OP_START)
                            sda_drive_low <= 1'b1;      // start edge
                        else if (op_q == OP_STOP)
                            sda_drive_low <= 1'b0;      // stop edge
                        else if (op_q == OP_SEND && ack_bit)
                            step.slave_nack <= sda_in;
                    end
                    default: if (op_q != OP_STOP) scl <= 1'b0;   // bus idles with scl high
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (step.go)
        begin
            op_q   <= step.op;
            nack_q <= step.send_nack;
            tx_sr  <= step.tx_byte;
        end
        else if (tick && !ack_bit)
        begin
            if (qtr == 2'd3 && op_q == OP_SEND)
                tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};     // msb first
            if (qtr == 2'd2 && op_q == OP_RECV)
                rx_sr <= {rx_sr[DATA_W-2:0], sda_in};
        end
    end

endmodule

// ==== rtl/eeprom_sequencer.sv ====
`timescale 1ns/1ns
module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    eeprom_req_if.taker                   req,
    i2c_step_if.master                    step,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          nack
);
    import eeprom_pkg::*;

    localparam int S_IDLE    = 0;
    localparam int S_START   = 1;
    localparam int S_CTRLW   = 2;
    localparam int S_ADDR    = 3;
    localparam int S_DATA    = 4;
    localparam int S_RESTART = 5;
    localparam int S_CTRLR   = 6;
    localparam int S_RECV    = 7;
    localparam int S_STOP    = 8;
    localparam int NSTATE    = 9;

    localparam logic [NSTATE-1:0] ONE = NSTATE'(1);

    logic [NSTATE-1:0] state;
    logic [NSTATE-1:0] state_nx;
    logic              cur_read;
    logic [ADDR_W-1:0] cur_addr;
    logic [DATA_W-1:0] cur_wdata;
    logic              nack_acc;
    logic              abort;
    logic              finish;

    assign req.take = state[S_IDLE] & req.pending;

    // slave refused a byte, skip to stop
    assign abort  = step.done & step.slave_nack &
                    (state[S_CTRLW] | state[S_ADDR] | state[S_DATA] | state[S_CTRLR]);
    assign finish = state[S_STOP] & step.done;

    always_comb
    begin
        state_nx = state;
        case (1'b1)
            state[S_IDLE]:    if (req.pending) state_nx = ONE << S_START;
            state[S_START]:   if (step.done) state_nx = ONE << S_CTRLW;
            state[S_CTRLW]:   if (step.done) state_nx = abort ? ONE << S_STOP : ONE << S_ADDR;
            state[S_ADDR]:
            begin
                if (abort)
                    state_nx = ONE << S_STOP;
                else if (step.done)
                    state_nx = cur_read ? ONE << S_RESTART : ONE << S_DATA;
            end
            state[S_DATA]:    if (step.done) state_nx = ONE << S_STOP;
            state[S_RESTART]: if (step.done) state_nx = ONE << S_CTRLR;
            state[S_CTRLR]:   if (step.done) state_nx = abort ? ONE << S_STOP : ONE << S_RECV;
            state[S_RECV]:    if (step.done) state_nx = ONE << S_STOP;
            state[S_STOP]:    if (step.done) state_nx = ONE << S_IDLE;
            default:          state_nx = ONE << S_IDLE;
        endcase
    end

    // operation follows the state, so it stays put from go to done
    always_comb
    begin
        step.op      = OP_SEND;
        step.tx_byte = cur_addr[DATA_W-1:0];
        if (state[S_START] | state[S_RESTART])
            step.op = OP_START;
        else if (state[S_RECV])
            step.op = OP_RECV;
        else if (state[S_STOP])
            step.op = OP_STOP;

        if (state[S_CTRLW])
            step.tx_byte = ctrl_byte(cur_addr[ADDR_W-1:DATA_W], 1'b0);
        else if (state[S_CTRLR])
            step.tx_byte = ctrl_byte(cur_addr[ADDR_W-1:DATA_W], 1'b1);
        else if (state[S_DATA])
            step.tx_byte = cur_wdata;
    end

    assign step.send_nack = state[S_RECV];  // single byte read ends with nack

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ONE << S_IDLE;
            step.go  <= 1'b0;
            ack      <= 1'b0;
            nack     <= 1'b0;
            nack_acc <= 1'b0;
        end
        else
        begin
            state   <= state_nx;
            step.go <= (state_nx != state) & ~state_nx[S_IDLE];   // one go per op state
            ack     <= finish;
            if (req.take)
                nack_acc <= 1'b0;
            else if (abort)
                nack_acc <= 1'b1;
            if (finish)
                nack <= nack_acc;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req.take)
        begin
            cur_read  <= req.is_read;
            cur_addr  <= req.addr;
            cur_wdata <= req.wdata;
        end
        if (finish)
            rdata <= step.rx_byte;
    end

endmodule

// ==== rtl/eeprom_request_stage.sv ====
`timescale 1ns/1ns
module eeprom_request_stage (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          busy,
    eeprom_req_if.holder                  req
);

    logic accept;

    // strobes are dropped while the slot is full
    assign accept = (wr | rd) & ~req.pending;
    assign busy   = req.pending;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            req.pending <= 1'b0;
        end
        else if (req.take)
        begin
            req.pending <= 1'b0;
        end
        else if (accept)
        begin
            req.pending <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.is_read <= ~wr;     // write wins
            req.addr    <= addr;
            req.wdata   <= wdata;
        end
    end

endmodule

// ==== rtl/i2c_step_if.sv ====
`timescale 1ns/1ns
interface i2c_step_if;
    import eeprom_pkg::*;

    i2c_op_t           op;
    logic [DATA_W-1:0] tx_byte;
    logic              send_nack;   // master answer for OP_RECV
    logic              go;
    logic              done;
    logic [DATA_W-1:0] rx_byte;
    logic              slave_nack;  // ack bit seen after OP_SEND

    modport master (
        output op, tx_byte, send_nack, go,
        input  done, rx_byte, slave_nack
    );

    modport engine (
        input  op, tx_byte, send_nack, go,
        output done, rx_byte, slave_nack
    );
endinterface

// ==== rtl/eeprom_req_if.sv ====
`timescale 1ns/1ns
interface eeprom_req_if;
    import eeprom_pkg::*;

    logic              pending;   // slot full
    logic              is_read;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              take;      // one cycle, from sequencer

    modport holder (
        output pending, is_read, addr, wdata,
        input  take
    );

    modport taker (
        input  pending, is_read, addr, wdata,
        output take
    );
endinterface

// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    // bus operations issued by the sequencer, OP_START doubles as repeated start
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_SEND  = 2'd1,
        OP_RECV  = 2'd2,
        OP_STOP  = 2'd3
    } i2c_op_t;

    localparam logic [3:0] DEV_CODE = 4'b1010;   // 24cxx device type
    localparam int         ADDR_W   = 11;
    localparam int         DATA_W   = 8;

    // control byte: device code, block number (addr 10..8), r/w bit
    function automatic logic [DATA_W-1:0] ctrl_byte(
        input logic [ADDR_W-DATA_W-1:0] block,
        input logic                     rnw
    );
        return {DEV_CODE, block, rnw};
    endfunction

endpackage
